//--- source/echo_pkg.sv
package echo_pkg;

    // **************************************************
    // measurement widths
    // **************************************************

    // cycle position inside one ping period.
    typedef logic [15:0] stamp_t;

    // frame total of stamps, also the published result.
    typedef logic [23:0] sum_t;

    // number of pings in a frame that heard an echo.
    typedef logic [7:0] hits_t;

    // **************************************************
    // serial link
    // **************************************************

    typedef logic [7:0] char_t;

    localparam char_t CHAR_CR = 8'h0d;
    localparam char_t CHAR_LF = 8'h0a;

    typedef enum logic [1:0] {
        TX_IDLE,
        TX_START,
        TX_DATA,
        TX_STOP
    } tx_state_t;

endpackage

//--- source/rf_edge_sync.sv
`timescale 1ns/100ps

module rf_edge_sync (
    input  logic clk,
    input  logic rst,
    input  logic rf_in,
    output logic rf_stb
);

    logic sync_1;
    logic sync_2;
    logic sync_3;

    // the first two flops bring rf_in into the clock domain.
    // the third one keeps the previous synchronized level for edge detection.
    always_ff @(posedge clk) begin
        if (rst) begin
            sync_1 <= 1'b0;
            sync_2 <= 1'b0;
            sync_3 <= 1'b0;
        end else begin
            sync_1 <= rf_in;
            sync_2 <= sync_1;
            sync_3 <= sync_2;
        end
    end

    // one cycle per rising edge of the synchronized level.
    assign rf_stb = sync_2 & ~sync_3;

endmodule

//--- source/echo_timer.sv
`timescale 1ns/100ps

module echo_timer #(
    parameter int PING_BITS       = 8,
    parameter int PINGS_PER_FRAME = 16
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             start,
    input  logic             rf_stb,
    output logic             tx_ping,
    output logic             measuring,
    output logic             ping_done,
    output logic             ping_hit,
    output logic             frame_end,
    output echo_pkg::stamp_t first_stamp,
    output echo_pkg::stamp_t last_stamp
);
    import echo_pkg::*;

    localparam logic [PING_BITS-1:0] CNT_MAX   = '1;
    localparam hits_t                LAST_PING = hits_t'(PINGS_PER_FRAME - 1);

    logic [PING_BITS-1:0] ping_cnt;
    hits_t                ping_idx;
    logic                 seen;
    stamp_t               first_q;
    stamp_t               last_q;
    stamp_t               cnt_stamp;
    logic                 ping_end;
    logic                 last_ping;

    assign cnt_stamp = stamp_t'(ping_cnt);
    assign ping_end  = measuring && (ping_cnt == CNT_MAX);
    assign last_ping = (ping_idx == LAST_PING);

    // **************************************************
    // frame and ping scheduling
    // **************************************************

    always_ff @(posedge clk) begin
        if (rst) begin
            measuring <= 1'b0;
            tx_ping   <= 1'b0;
            ping_done <= 1'b0;
            ping_cnt  <= '0;
            ping_idx  <= '0;
            seen      <= 1'b0;
        end else begin
            tx_ping   <= 1'b0;
            ping_done <= 1'b0;
            if (!measuring) begin
                if (start) begin
                    measuring <= 1'b1;
                    tx_ping   <= 1'b1;
                    ping_cnt  <= '0;
                    ping_idx  <= '0;
                    seen      <= 1'b0;
                end
            end else begin
                // the counter wraps to zero exactly in the next tx_ping cycle.
                ping_cnt <= ping_cnt + 1'b1;
                if (ping_end) begin
                    ping_done <= 1'b1;
                    seen      <= 1'b0;
                    if (last_ping) begin
                        measuring <= 1'b0;
                    end else begin
                        tx_ping  <= 1'b1;
                        ping_idx <= ping_idx + 1'b1;
                    end
                end else if (rf_stb) begin
                    seen <= 1'b1;
                end
            end
        end
    end

    // **************************************************
    // echo stamps
    // **************************************************

    always_ff @(posedge clk) begin
        if (measuring && rf_stb) begin
            if (!seen) begin
                first_q <= cnt_stamp;
            end
            last_q <= cnt_stamp;
        end

        // an echo in the last counter cycle still belongs to the ending ping.
        if (ping_end) begin
            ping_hit    <= seen || rf_stb;
            first_stamp <= seen ? first_q : cnt_stamp;
            last_stamp  <= rf_stb ? cnt_stamp : last_q;
            frame_end   <= last_ping;
        end
    end

endmodule

//--- source/echo_accumulator.sv
`timescale 1ns/100ps

module echo_accumulator (
    input  logic             clk,
    input  logic             rst,
    input  logic             ping_done,
    input  logic             ping_hit,
    input  logic             frame_end,
    input  echo_pkg::stamp_t first_stamp,
    input  echo_pkg::stamp_t last_stamp,
    output logic             result_valid,
    output echo_pkg::sum_t   result_value,
    output echo_pkg::hits_t  result_hits
);
    import echo_pkg::*;

    sum_t  first_total;
    sum_t  last_total;
    hits_t hit_count;
    sum_t  first_next;
    sum_t  last_next;
    hits_t hits_next;

    // totals including the ping that is being reported now.
    always_comb begin
        first_next = first_total;
        last_next  = last_total;
        hits_next  = hit_count;
        if (ping_hit) begin
            first_next = first_total + sum_t'(first_stamp);
            last_next  = last_total + sum_t'(last_stamp);
            hits_next  = hit_count + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            first_total  <= '0;
            last_total   <= '0;
            hit_count    <= '0;
            result_valid <= 1'b0;
            result_value <= '0;
            result_hits  <= '0;
        end else begin
            result_valid <= 1'b0;
            if (ping_done) begin
                if (frame_end) begin
                    // publish the frame and start the next one from zero.
                    result_value <= first_next + last_next;
                    result_hits  <= hits_next;
                    result_valid <= 1'b1;
                    first_total  <= '0;
                    last_total   <= '0;
                    hit_count    <= '0;
                end else begin
                    first_total <= first_next;
                    last_total  <= last_next;
                    hit_count   <= hits_next;
                end
            end
        end
    end

endmodule

//--- source/hex_uart_tx.sv
`timescale 1ns/100ps

module hex_uart_tx #(
    parameter int BAUD_DIV = 40000
) (
    input  logic           clk,
    input  logic           rst,
    input  logic           result_valid,
    input  echo_pkg::sum_t result_value,
    output logic           serial_tx,
    output logic           tx_busy
);
    import echo_pkg::*;

    localparam int CNT_W     = (BAUD_DIV > 1) ? $clog2(BAUD_DIV) : 1;
    localparam int SUM_W     = $bits(sum_t);
    localparam int HEX_CHARS = SUM_W / 4;

    tx_state_t        state;
    logic [CNT_W-1:0] baud_cnt;
    logic [2:0]       bit_idx;
    logic [2:0]       char_idx;
    sum_t             value_q;
    char_t            cur_char;
    logic [2:0]       next_bit;
    logic             bit_end;

    assign bit_end  = (baud_cnt == CNT_W'(BAUD_DIV - 1));
    assign next_bit = bit_idx + 3'd1;

    function automatic char_t hex_char(input logic [3:0] nibble);
        if (nibble < 4'd10) begin
            return char_t'(8'h30 + nibble);
        end
        return char_t'(8'h37 + nibble);
    endfunction

    // **************************************************
    // character selection
    // **************************************************

    // value_q is shifted after each digit, so its top nibble is the current one.
    always_comb begin
        if (char_idx < 3'(HEX_CHARS)) begin
            cur_char = hex_char(value_q[SUM_W-1 -: 4]);
        end else if (char_idx == 3'(HEX_CHARS)) begin
            cur_char = CHAR_CR;
        end else begin
            cur_char = CHAR_LF;
        end
    end

    // **************************************************
    // 8N1 shifter
    // **************************************************

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= TX_IDLE;
            baud_cnt  <= '0;
            bit_idx   <= '0;
            char_idx  <= '0;
            serial_tx <= 1'b1;
            tx_busy   <= 1'b0;
        end else begin
            if (state != TX_IDLE) begin
                baud_cnt <= bit_end ? '0 : baud_cnt + 1'b1;
            end
            case (state)
                TX_IDLE: begin
                    serial_tx <= 1'b1;
                    if (result_valid) begin
                        value_q   <= result_value;
                        baud_cnt  <= '0;
                        char_idx  <= '0;
                        serial_tx <= 1'b0;
                        tx_busy   <= 1'b1;
                        state     <= TX_START;
                    end
                end
                TX_START: begin
                    if (bit_end) begin
                        bit_idx   <= '0;
                        serial_tx <= cur_char[0];
                        state     <= TX_DATA;
                    end
                end
                TX_DATA: begin
                    if (bit_end) begin
                        if (bit_idx == 3'd7) begin
                            serial_tx <= 1'b1;
                            state     <= TX_STOP;
                        end else begin
                            bit_idx   <= next_bit;
                            serial_tx <= cur_char[next_bit];
                        end
                    end
                end
                TX_STOP: begin
                    if (bit_end) begin
                        if (char_idx == 3'd7) begin
                            tx_busy <= 1'b0;
                            state   <= TX_IDLE;
                        end else begin
                            char_idx  <= char_idx + 3'd1;
                            value_q   <= value_q << 4;
                            serial_tx <= 1'b0;
                            state     <= TX_START;
                        end
                    end
                end
                default: begin
                    state <= TX_IDLE;
                end
            endcase
        end
    end

endmodule

//--- source/echo_top.sv
`timescale 1ns/100ps

module echo_top #(
    parameter int PING_BITS       = 8,
    parameter int PINGS_PER_FRAME = 16,
    parameter int BAUD_DIV        = 40000
) (
    input  logic            clk,
    input  logic            rst,
    input  logic            start,
    input  logic            rf_in,
    output logic            tx_ping,
    output logic            measuring,
    output logic            result_valid,
    output echo_pkg::sum_t  result_value,
    output echo_pkg::hits_t result_hits,
    output logic            serial_tx,
    output logic            tx_busy
);
    import echo_pkg::*;

    logic   rf_stb;
    logic   ping_done;
    logic   ping_hit;
    logic   frame_end;
    stamp_t first_stamp;
    stamp_t last_stamp;

    rf_edge_sync u_sync (
        .clk    (clk),
        .rst    (rst),
        .rf_in  (rf_in),
        .rf_stb (rf_stb)
    );

    echo_timer #(
        .PING_BITS       (PING_BITS),
        .PINGS_PER_FRAME (PINGS_PER_FRAME)
    ) u_timer (
        .clk         (clk),
        .rst         (rst),
        .start       (start),
        .rf_stb      (rf_stb),
        .tx_ping     (tx_ping),
        .measuring   (measuring),
        .ping_done   (ping_done),
        .ping_hit    (ping_hit),
        .frame_end   (frame_end),
        .first_stamp (first_stamp),
        .last_stamp  (last_stamp)
    );

    echo_accumulator u_accum (
        .clk          (clk),
        .rst          (rst),
        .ping_done    (ping_done),
        .ping_hit     (ping_hit),
        .frame_end    (frame_end),
        .first_stamp  (first_stamp),
        .last_stamp   (last_stamp),
        .result_valid (result_valid),
        .result_value (result_value),
        .result_hits  (result_hits)
    );

    hex_uart_tx #(
        .BAUD_DIV (BAUD_DIV)
    ) u_uart (
        .clk          (clk),
        .rst          (rst),
        .result_valid (result_valid),
        .result_value (result_value),
        .serial_tx    (serial_tx),
        .tx_busy      (tx_busy)
    );

endmodule

//--- test/echo_props.sv
`timescale 1ns/100ps

module echo_props #(
    parameter int PING_BITS = 8,
    parameter int BAUD_DIV  = 40000
) (
    input logic            clk,
    input logic            rst,
    input logic            start,
    input logic            tx_ping,
    input logic            measuring,
    input logic            result_valid,
    input echo_pkg::sum_t  result_value,
    input echo_pkg::hits_t result_hits,
    input logic            serial_tx,
    input logic            tx_busy
);

    localparam int PERIOD     = 2 ** PING_BITS;
    localparam int MSG_CYCLES = 8 * 10 * BAUD_DIV;

    logic started;
    logic ping_armed;
    int   ping_gap;
    int   busy_len;

    // ping_gap counts the cycles since the last tx_ping of the running frame.
    always_ff @(posedge clk) begin
        if (rst) begin
            started    <= 1'b0;
            ping_armed <= 1'b0;
            ping_gap   <= 0;
            busy_len   <= 0;
        end else begin
            if (start) begin
                started <= 1'b1;
            end
            if (!measuring) begin
                ping_armed <= 1'b0;
            end else if (tx_ping) begin
                ping_armed <= 1'b1;
            end
            ping_gap <= tx_ping ? 0 : ping_gap + 1;
            busy_len <= tx_busy ? busy_len + 1 : 0;
        end
    end

    // **************************************************
    // ping schedule
    // **************************************************

    idle_after_reset: assert property (@(posedge clk) disable iff (rst)
        !started |-> (!tx_ping && !measuring && !result_valid && !tx_busy && serial_tx))
        else $error("outputs active before the first start");

    ping_spacing: assert property (@(posedge clk) disable iff (rst)
        (tx_ping && ping_armed) |-> (ping_gap == PERIOD - 1))
        else $error("tx_ping arrived off its period");

    ping_missing: assert property (@(posedge clk) disable iff (rst)
        (measuring && ping_armed && ping_gap == PERIOD - 1) |-> tx_ping)
        else $error("tx_ping missing at the end of a ping period");

    ping_in_frame: assert property (@(posedge clk) disable iff (rst)
        tx_ping |-> measuring)
        else $error("tx_ping outside a frame");

    // **************************************************
    // result and serial link
    // **************************************************

    valid_pulse: assert property (@(posedge clk) disable iff (rst)
        result_valid |=> !result_valid)
        else $error("result_valid longer than one cycle");

    result_held: assert property (@(posedge clk) disable iff (rst)
        !result_valid |-> ($stable(result_value) && $stable(result_hits)))
        else $error("result changed without result_valid");

    busy_start: assert property (@(posedge clk) disable iff (rst)
        (result_valid && !tx_busy) |=> tx_busy)
        else $error("tx_busy did not rise after result_valid");

    busy_cause: assert property (@(posedge clk) disable iff (rst)
        $rose(tx_busy) |-> $past(result_valid))
        else $error("tx_busy rose without result_valid");

    busy_length: assert property (@(posedge clk) disable iff (rst)
        $fell(tx_busy) |-> (busy_len == MSG_CYCLES))
        else $error("tx_busy length differs from one message");

endmodule

bind echo_top echo_props #(
    .PING_BITS (PING_BITS),
    .BAUD_DIV  (BAUD_DIV)
) u_props (
    .clk          (clk),
    .rst          (rst),
    .start        (start),
    .tx_ping      (tx_ping),
    .measuring    (measuring),
    .result_valid (result_valid),
    .result_value (result_value),
    .result_hits  (result_hits),
    .serial_tx    (serial_tx),
    .tx_busy      (tx_busy)
);

//--- test/echo_tb.sv
`timescale 1ns/100ps

module echo_tb;
    import echo_pkg::*;

    localparam int PING_BITS       = 6;
    localparam int PINGS_PER_FRAME = 4;
    localparam int BAUD_DIV        = 8;
    localparam int FRAMES          = 3;
    localparam int PERIOD          = 2 ** PING_BITS;
    localparam int MSG_CHARS       = 8;
    // frames and messages back to back, with room for reset and idle gaps.
    localparam int WATCHDOG_CYCLES = FRAMES * PINGS_PER_FRAME * PERIOD
                                   + FRAMES * MSG_CHARS * 10 * BAUD_DIV + 500;

    logic  clk = 1'b0;
    logic  rst;
    logic  start;
    logic  rf_in;
    logic  tx_ping;
    logic  measuring;
    logic  result_valid;
    sum_t  result_value;
    hits_t result_hits;
    logic  serial_tx;
    logic  tx_busy;

    sum_t        exp_value;
    hits_t       exp_hits;
    sum_t        sent_values[$];
    int          ping_count   = 0;
    int          result_count = 0;
    int          msg_count    = 0;
    logic [31:0] rng;

    echo_top #(
        .PING_BITS       (PING_BITS),
        .PINGS_PER_FRAME (PINGS_PER_FRAME),
        .BAUD_DIV        (BAUD_DIV)
    ) uut (
        .clk          (clk),
        .rst          (rst),
        .start        (start),
        .rf_in        (rf_in),
        .tx_ping      (tx_ping),
        .measuring    (measuring),
        .result_valid (result_valid),
        .result_value (result_value),
        .result_hits  (result_hits),
        .serial_tx    (serial_tx),
        .tx_busy      (tx_busy)
    );

    always #20 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] s;
        s = x;
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    // six upper-case hex digits, most significant first, then CR and LF.
    function automatic char_t expected_char(input sum_t v, input int idx);
        logic [3:0] nib;
        if (idx == 6) begin
            return 8'h0d;
        end
        if (idx == 7) begin
            return 8'h0a;
        end
        nib = v[23 - 4 * idx -: 4];
        if (nib < 4'd10) begin
            return 8'h30 + {4'h0, nib};
        end
        return 8'h41 + {4'h0, nib} - 8'd10;
    endfunction

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("ERRORS FOUND");
        $fatal(1);
    endtask

    // drives one ping period, entered on the edge that shows tx_ping.
    task automatic run_ping(input logic hit, input int d1, input int d2, input logic poke);
        for (int k = 0; k < PERIOD - 1; k++) begin
            if (hit && (k == d1 || k == d2)) begin
                rf_in <= 1'b1;
            end
            if (hit && (k == d1 + 2 || k == d2 + 2)) begin
                rf_in <= 1'b0;
            end
            if (poke) begin
                start <= (k == 20);
            end
            @(posedge clk);
        end
    endtask

    // **************************************************
    // stimulus
    // **************************************************

    initial begin
        logic hit;
        int   d1;
        int   d2;
        rst       = 1'b1;
        start     = 1'b0;
        rf_in     = 1'b0;
        exp_value = '0;
        exp_hits  = '0;
        rng       = 32'h9f92;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        for (int f = 0; f < FRAMES; f++) begin
            exp_value = '0;
            exp_hits  = '0;
            @(posedge clk);
            start <= 1'b1;
            @(posedge clk);
            start <= 1'b0;
            for (int p = 0; p < PINGS_PER_FRAME; p++) begin
                do begin
                    @(posedge clk);
                end while (!tx_ping);
                rng = xorshift32(rng);
                hit = (f != 1) && (rng[1:0] != 2'b00);
                d1  = int'(rng[10:5]) % 40;
                d2  = rng[2] ? d1 + 4 + int'(rng[15:12]) % 12 : d1;
                // the last frame ends with an echo on the top counter value.
                if (f == 2 && p == PINGS_PER_FRAME - 1) begin
                    hit = 1'b1;
                    d2  = PERIOD - 4;
                end
                if (hit) begin
                    // a rise of rf_in is stamped three counts later.
                    exp_value = exp_value + sum_t'(d1 + 3) + sum_t'(d2 + 3);
                    exp_hits  = exp_hits + hits_t'(1);
                end
                run_ping(hit, d1, d2, f == 0 && p == 1);
            end
            while (msg_count <= f) @(posedge clk);
        end
        while (tx_busy) @(posedge clk);
        repeat (10) @(posedge clk);
        if (result_count != FRAMES || msg_count != FRAMES || sent_values.size() != 0) begin
            report_failure($sformatf("run ended with %0d results and %0d messages, %0d expected",
                                     result_count, msg_count, FRAMES));
        end else begin
            $display("NO ERRORS");
            $finish;
        end
    end

    // **************************************************
    // result and serial checks
    // **************************************************

    always @(posedge clk) begin
        if (!rst && tx_ping) begin
            ping_count = ping_count + 1;
        end
        if (!rst && result_valid) begin
            assert (result_value == exp_value) else report_failure($sformatf(
                "MISMATCH result_value: got %h expected %h", result_value, exp_value));
            assert (result_hits == exp_hits) else report_failure($sformatf(
                "MISMATCH result_hits: got %h expected %h", result_hits, exp_hits));
            assert (ping_count == PINGS_PER_FRAME) else report_failure($sformatf(
                "MISMATCH tx_ping count: got %h expected %h", ping_count, PINGS_PER_FRAME));
            sent_values.push_back(exp_value);
            ping_count   = 0;
            result_count = result_count + 1;
        end
    end

    // samples each bit in its middle, counted from the first low cycle.
    initial begin
        char_t c;
        int    idx;
        idx = 0;
        forever begin
            do begin
                @(posedge clk);
            end while (rst || serial_tx);
            repeat (BAUD_DIV / 2) @(posedge clk);
            assert (!serial_tx) else report_failure("serial start bit ended before its middle");
            for (int i = 0; i < 8; i++) begin
                repeat (BAUD_DIV) @(posedge clk);
                c[i] = serial_tx;
            end
            repeat (BAUD_DIV) @(posedge clk);
            assert (serial_tx) else report_failure($sformatf(
                "stop bit of serial character %0d was low", idx));
            assert (sent_values.size() != 0) else report_failure(
                "serial character arrived with no published result");
            assert (c == expected_char(sent_values[0], idx)) else report_failure($sformatf(
                "MISMATCH serial_tx char %0d: got %h expected %h",
                idx, c, expected_char(sent_values[0], idx)));
            idx = idx + 1;
            if (idx == MSG_CHARS) begin
                void'(sent_values.pop_front());
                msg_count = msg_count + 1;
                idx       = 0;
            end
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        report_failure($sformatf("run did not finish within %0d clock cycles",
                                 WATCHDOG_CYCLES));
    end

endmodule

//--- verilog.f
source/echo_pkg.sv
source/rf_edge_sync.sv
source/echo_timer.sv
source/echo_accumulator.sv
source/hex_uart_tx.sv
source/echo_top.sv
test/echo_props.sv
test/echo_tb.sv

//--- Makefile
SIM = obj_dir/echo_sim

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module echo_tb -f verilog.f -o echo_sim

run: compile
	./$(SIM)

clean:
	rm -rf obj_dir
